// File: hdl/lsu_pkg.sv
/*
 * Shared LSU definitions: width types, operation codes, access sizes,
 * result kinds and the packed structs passed between pipeline stages
 */

package lsu_pkg;

    typedef logic [31:0]  addr_t;
    typedef logic [31:0]  data_t;
    typedef logic [4:0]   tag_t;

    localparam int LINE_BYTES = 16;
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // Low two bits of a load or store code give its access size
    typedef logic [3:0] op_t;
    localparam op_t OP_LB   = 4'h0;
    localparam op_t OP_LH   = 4'h1;
    localparam op_t OP_LW   = 4'h2;
    localparam op_t OP_LBU  = 4'h4;
    localparam op_t OP_LHU  = 4'h5;
    localparam op_t OP_SB   = 4'h8;
    localparam op_t OP_SH   = 4'h9;
    localparam op_t OP_SW   = 4'ha;
    localparam op_t OP_FILL = 4'hf;

    typedef logic [1:0] size_t;
    localparam size_t SIZE_B = 2'd0;
    localparam size_t SIZE_H = 2'd1;
    localparam size_t SIZE_W = 2'd2;

    typedef logic [1:0] kind_t;
    localparam kind_t KIND_DONE    = 2'd0;
    localparam kind_t KIND_RETIRED = 2'd1;
    localparam kind_t KIND_MISS    = 2'd2;

    typedef struct packed {
        logic is_ld;
        logic is_st;
        logic is_fill;
    } op_is_t;

    localparam op_is_t OP_IS_NONE = '{is_ld: 1'b0, is_st: 1'b0, is_fill: 1'b0};
    localparam op_is_t OP_IS_LD   = '{is_ld: 1'b1, is_st: 1'b0, is_fill: 1'b0};
    localparam op_is_t OP_IS_ST   = '{is_ld: 1'b0, is_st: 1'b1, is_fill: 1'b0};
    localparam op_is_t OP_IS_FILL = '{is_ld: 1'b0, is_st: 1'b0, is_fill: 1'b1};

    typedef struct packed {
        logic   valid;
        op_t    op;
        op_is_t op_is;
        tag_t   tag;
        addr_t  addr;
        data_t  data;
        logic   retire;
        logic   replay;
        logic   fill;
        line_t  fill_line;
    } am_out_t;

    typedef struct packed {
        logic   valid;
        op_t    op;
        op_is_t op_is;
        tag_t   tag;
        addr_t  addr;
        data_t  rdata;
        logic   hit;
        logic   retire;
        logic   replay;
    } exec_out_t;

    typedef struct packed {
        logic  valid;
        kind_t kind;
        tag_t  tag;
        data_t data;
        addr_t addr;
    } result_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
        line_t line;
    } fill_t;

    typedef struct packed {
        logic  en;
        tag_t  tag;
        addr_t addr;
        data_t data;
        op_t   op;
    } retire_t;

    typedef struct packed {
        logic  en;
        tag_t  tag;
        addr_t addr;
        op_t   op;
    } replay_t;

endpackage

// File: hdl/lsu_decode.sv
/*
 * Operation decoder: class bits, access size and sign of an LSU op code
 */

`timescale 1ns/1ps

module lsu_decode (
    input  lsu_pkg::op_t    i_op,
    output lsu_pkg::op_is_t o_op_is,
    output lsu_pkg::size_t  o_size,
    output logic            o_signed
);

    import lsu_pkg::*;

    always_comb begin
        o_op_is  = OP_IS_NONE;
        o_size   = size_t'(i_op[1:0]);
        o_signed = 1'b0;

        case (i_op)
            OP_LB, OP_LH, OP_LW: begin
                o_op_is  = OP_IS_LD;
                o_signed = 1'b1;
            end
            OP_LBU, OP_LHU: begin
                o_op_is = OP_IS_LD;
            end
            OP_SB, OP_SH, OP_SW: begin
                o_op_is = OP_IS_ST;
            end
            OP_FILL: begin
                // Fills move a whole line, size only matters for word reads
                o_op_is = OP_IS_FILL;
                o_size  = SIZE_W;
            end
            default: begin
                // Unknown code, no class so nothing downstream acts on it
                o_size = SIZE_W;
            end
        endcase
    end

endmodule

// File: hdl/lsu_am.sv
/*
 * Address generation and source mux stage: picks fill, retire, replay or
 * new op by priority, raises stalls and allocates load/store queue entries
 */

`timescale 1ns/1ps

module lsu_am (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_flush,
    input  logic             i_lq_full,
    input  logic             i_sq_full,
    input  logic             i_valid,
    input  lsu_pkg::op_t     i_op,
    input  lsu_pkg::op_is_t  i_op_is,
    input  lsu_pkg::data_t   i_imm,
    input  lsu_pkg::data_t   i_src_base,
    input  lsu_pkg::data_t   i_src_data,
    input  lsu_pkg::tag_t    i_tag,
    input  lsu_pkg::fill_t   i_fill,
    input  lsu_pkg::retire_t i_retire,
    input  lsu_pkg::replay_t i_replay,
    output logic             o_stall,
    output logic             o_sq_retire_stall,
    output logic             o_lq_replay_stall,
    output lsu_pkg::am_out_t o_am,
    output logic             o_alloc_lq_en,
    output logic             o_alloc_sq_en,
    output lsu_pkg::op_t     o_alloc_op,
    output lsu_pkg::tag_t    o_alloc_tag,
    output lsu_pkg::addr_t   o_alloc_addr,
    output lsu_pkg::data_t   o_alloc_data
);

    import lsu_pkg::*;

    addr_t   addr;
    logic    lq_full;
    logic    sq_full;
    logic    rs_stall;
    logic    new_acc;
    am_out_t am_d;
    am_out_t am_q;
    logic    am_valid_q;

    assign addr = i_src_base + i_imm;

    // Queue full only matters for an op that would land in that queue
    assign lq_full = i_lq_full & i_op_is.is_ld;
    assign sq_full = i_sq_full & i_op_is.is_st;

    // Any pending fill, retire or replay takes the slot from the RS
    assign rs_stall = lq_full | sq_full | i_fill.en | i_retire.en | i_replay.en;
    assign o_stall  = rs_stall;

    assign o_sq_retire_stall = i_flush | i_fill.en;
    assign o_lq_replay_stall = i_retire.en | i_fill.en;

    assign new_acc = i_valid & ~rs_stall & ~i_flush;

    always_comb begin
        // Fill survives a flush, everything else is squashed
        am_d.valid = i_fill.en |
                     (~i_flush & ((i_valid & ~rs_stall) | i_retire.en | i_replay.en));
        am_d.data      = i_retire.data;
        am_d.retire    = ~i_fill.en & i_retire.en;
        am_d.replay    = ~i_fill.en & ~i_retire.en & i_replay.en;
        am_d.fill      = i_fill.en;
        am_d.fill_line = i_fill.line;

        if (i_fill.en) begin
            am_d.op    = OP_FILL;
            am_d.op_is = OP_IS_FILL;
            am_d.tag   = '0;
            am_d.addr  = i_fill.addr;
        end else if (i_retire.en) begin
            am_d.op    = i_retire.op;
            am_d.op_is = OP_IS_ST;
            am_d.tag   = i_retire.tag;
            am_d.addr  = i_retire.addr;
        end else if (i_replay.en) begin
            am_d.op    = i_replay.op;
            am_d.op_is = OP_IS_LD;
            am_d.tag   = i_replay.tag;
            am_d.addr  = i_replay.addr;
        end else begin
            am_d.op    = i_op;
            am_d.op_is = i_op_is;
            am_d.tag   = i_tag;
            am_d.addr  = addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            am_valid_q    <= 1'b0;
            o_alloc_lq_en <= 1'b0;
            o_alloc_sq_en <= 1'b0;
        end else begin
            am_valid_q    <= am_d.valid;
            o_alloc_lq_en <= new_acc & i_op_is.is_ld;
            o_alloc_sq_en <= new_acc & i_op_is.is_st;
        end
    end

    always_ff @(posedge clk) begin
        am_q         <= am_d;
        o_alloc_op   <= i_op;
        o_alloc_tag  <= i_tag;
        o_alloc_addr <= addr;
        o_alloc_data <= i_src_data;
    end

    always_comb begin
        o_am       = am_q;
        o_am.valid = am_valid_q;
    end

endmodule

// File: hdl/lsu_exec.sv
/*
 * Execute stage: direct-mapped data cache with tag check, line fill,
 * store byte merge on retire and a registered word read
 */

`timescale 1ns/1ps

module lsu_exec #(
    parameter int DC_NUM_LINES = 8
) (
    input  logic               clk,
    input  logic               i_rst_n,
    input  lsu_pkg::am_out_t   i_am,
    output lsu_pkg::exec_out_t o_exec
);

    import lsu_pkg::*;

    localparam int OFF_W  = $clog2(LINE_BYTES);
    localparam int IDX_W  = $clog2(DC_NUM_LINES);
    localparam int CTAG_W = $bits(addr_t) - IDX_W - OFF_W;

    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [CTAG_W-1:0] ctag_t;

    ctag_t                   tag_mem [DC_NUM_LINES];
    line_t                   data_mem [DC_NUM_LINES];
    logic [DC_NUM_LINES-1:0] line_valid;

    idx_t      idx;
    ctag_t     ctag;
    logic [1:0] word_sel;
    logic      hit;
    logic      do_fill;
    logic      do_retire;
    size_t     st_size;
    logic [3:0] byte_en;
    data_t     st_word;
    line_t     merged;
    exec_out_t exec_d;
    exec_out_t exec_q;
    logic      exec_valid_q;

    assign idx      = i_am.addr[OFF_W +: IDX_W];
    assign ctag     = i_am.addr[OFF_W + IDX_W +: CTAG_W];
    assign word_sel = i_am.addr[OFF_W-1:2];

    assign hit       = line_valid[idx] & (tag_mem[idx] == ctag);
    assign do_fill   = i_am.valid & i_am.fill;
    assign do_retire = i_am.valid & i_am.retire & hit;

    // Place store data on its byte lanes, then merge into the current line
    always_comb begin
        st_size = size_t'(i_am.op[1:0]);
        case (st_size)
            SIZE_B: begin
                byte_en = 4'b0001 << i_am.addr[1:0];
                st_word = {4{i_am.data[7:0]}};
            end
            SIZE_H: begin
                byte_en = 4'b0011 << {i_am.addr[1], 1'b0};
                st_word = {2{i_am.data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                st_word = i_am.data;
            end
        endcase

        merged = data_mem[idx];
        for (int b = 0; b < 4; b++) begin
            if (byte_en[b]) begin
                merged[word_sel*32 + b*8 +: 8] = st_word[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_fill) begin
            tag_mem[idx]  <= ctag;
            data_mem[idx] <= i_am.fill_line;
        end else if (do_retire) begin
            data_mem[idx] <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            line_valid <= '0;
        end else if (do_fill) begin
            line_valid[idx] <= 1'b1;
        end
    end

    always_comb begin
        exec_d.valid  = i_am.valid;
        exec_d.op     = i_am.op;
        exec_d.op_is  = i_am.op_is;
        exec_d.tag    = i_am.tag;
        exec_d.addr   = i_am.addr;
        exec_d.rdata  = data_mem[idx][word_sel*32 +: 32];
        exec_d.hit    = hit;
        exec_d.retire = i_am.retire;
        exec_d.replay = i_am.replay;
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            exec_valid_q <= 1'b0;
        end else begin
            exec_valid_q <= exec_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        exec_q <= exec_d;
    end

    always_comb begin
        o_exec       = exec_q;
        o_exec.valid = exec_valid_q;
    end

endmodule

// File: hdl/lsu_result.sv
/*
 * Result stage: load byte/half select with sign or zero extension,
 * result kind selection and the registered result
 */

`timescale 1ns/1ps

module lsu_result (
    input  logic               clk,
    input  logic               i_rst_n,
    input  lsu_pkg::exec_out_t i_exec,
    output lsu_pkg::result_t   o_result
);

    import lsu_pkg::*;

    size_t   size;
    logic    is_signed;
    data_t   shifted;
    data_t   ext;
    result_t res_d;
    result_t res_q;
    logic    res_valid_q;

    lsu_decode i_lsu_decode (
        .i_op     (i_exec.op),
        .o_op_is  (),
        .o_size   (size),
        .o_signed (is_signed)
    );

    always_comb begin
        shifted = i_exec.rdata >> {i_exec.addr[1:0], 3'b000};
        case (size)
            SIZE_B:  ext = {{24{is_signed & shifted[7]}}, shifted[7:0]};
            SIZE_H:  ext = {{16{is_signed & shifted[15]}}, shifted[15:0]};
            default: ext = shifted;
        endcase
    end

    always_comb begin
        // Fills and unknown ops carry no class bit and report nothing
        res_d.valid = i_exec.valid & (i_exec.op_is.is_ld | i_exec.op_is.is_st);
        res_d.tag   = i_exec.tag;
        res_d.addr  = i_exec.addr;
        res_d.kind  = KIND_DONE;
        res_d.data  = '0;

        if (i_exec.retire) begin
            res_d.kind = i_exec.hit ? KIND_RETIRED : KIND_MISS;
        end else if (i_exec.op_is.is_ld) begin
            if (i_exec.hit) begin
                res_d.data = ext;
            end else begin
                res_d.kind = KIND_MISS;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= res_d.valid;
        end
    end

    always_ff @(posedge clk) begin
        res_q <= res_d;
    end

    always_comb begin
        o_result       = res_q;
        o_result.valid = res_valid_q;
    end

endmodule

// File: hdl/lsu_top.sv
/*
 * LSU front end: decode, address mux, data cache and result stages
 */

`timescale 1ns/1ps

module lsu_top #(
    parameter int DC_NUM_LINES = 8
) (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_flush,
    input  logic             i_valid,
    input  lsu_pkg::op_t     i_op,
    input  lsu_pkg::data_t   i_imm,
    input  lsu_pkg::data_t   i_src_base,
    input  lsu_pkg::data_t   i_src_data,
    input  lsu_pkg::tag_t    i_tag,
    output logic             o_stall,
    input  lsu_pkg::fill_t   i_fill,
    input  lsu_pkg::retire_t i_retire,
    input  logic             i_sq_full,
    output logic             o_sq_retire_stall,
    input  lsu_pkg::replay_t i_replay,
    input  logic             i_lq_full,
    output logic             o_lq_replay_stall,
    output logic             o_alloc_lq_en,
    output logic             o_alloc_sq_en,
    output lsu_pkg::op_t     o_alloc_op,
    output lsu_pkg::tag_t    o_alloc_tag,
    output lsu_pkg::addr_t   o_alloc_addr,
    output lsu_pkg::data_t   o_alloc_data,
    output lsu_pkg::result_t o_result
);

    import lsu_pkg::*;

    op_is_t    op_is;
    am_out_t   am_out;
    exec_out_t exec_out;

    lsu_decode i_lsu_decode (
        .i_op     (i_op),
        .o_op_is  (op_is),
        .o_size   (),
        .o_signed ()
    );

    lsu_am i_lsu_am (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_flush           (i_flush),
        .i_lq_full         (i_lq_full),
        .i_sq_full         (i_sq_full),
        .i_valid           (i_valid),
        .i_op              (i_op),
        .i_op_is           (op_is),
        .i_imm             (i_imm),
        .i_src_base        (i_src_base),
        .i_src_data        (i_src_data),
        .i_tag             (i_tag),
        .i_fill            (i_fill),
        .i_retire          (i_retire),
        .i_replay          (i_replay),
        .o_stall           (o_stall),
        .o_sq_retire_stall (o_sq_retire_stall),
        .o_lq_replay_stall (o_lq_replay_stall),
        .o_am              (am_out),
        .o_alloc_lq_en     (o_alloc_lq_en),
        .o_alloc_sq_en     (o_alloc_sq_en),
        .o_alloc_op        (o_alloc_op),
        .o_alloc_tag       (o_alloc_tag),
        .o_alloc_addr      (o_alloc_addr),
        .o_alloc_data      (o_alloc_data)
    );

    lsu_exec #(
        .DC_NUM_LINES (DC_NUM_LINES)
    ) i_lsu_exec (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_am    (am_out),
        .o_exec  (exec_out)
    );

    lsu_result i_lsu_result (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_exec   (exec_out),
        .o_result (o_result)
    );

endmodule

// File: test/lsu_clkgen.sv
/*
 * Testbench clock and reset source, 20 ns period, reset low for 3 cycles
 */

`timescale 1ns/1ps

module lsu_clkgen #(
    parameter int PERIOD_NS = 20
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n = 1'b1;
    end

endmodule

// File: test/lsu_tb.sv
/*
 * LSU testbench with random RS, store queue, load queue and fill traffic,
 * a direct-mapped cache model with a pattern memory, checks and watchdog
 */

`timescale 1ns/1ps

module lsu_tb;

    import lsu_pkg::*;

    localparam int N_OPS = 2000;
    localparam int SETS  = 8;
    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(SETS);

    typedef struct packed {
        int      stamp;
        result_t res;
    } exp_t;

    logic clk, rst_n, valid, flush, lq_full, sq_full;
    op_t     op;
    data_t   imm, base, sdata;
    tag_t    tag;
    fill_t   fill;
    retire_t retire;
    replay_t replay;
    logic    stall, sq_stall, lq_stall, alloc_lq_en, alloc_sq_en;
    op_t     alloc_op;
    tag_t    alloc_tag;
    addr_t   alloc_addr;
    data_t   alloc_data;
    result_t result;

    // Cache model and expected traffic
    line_t           m_line [SETS];
    addr_t           m_tag  [SETS];
    logic [SETS-1:0] m_valid;
    exp_t            exp_q [$];
    replay_t         miss_q [$];
    logic            exp_lq, exp_sq, ret_taken;
    op_t             exp_op;
    tag_t            exp_tag;
    addr_t           exp_addr;
    data_t           exp_data;
    int              errors, checks;

    lsu_clkgen i_lsu_clkgen (.o_clk(clk), .o_rst_n(rst_n));

    lsu_top #(.DC_NUM_LINES(SETS)) i_lsu_top (
        .clk(clk), .i_rst_n(rst_n), .i_flush(flush), .i_valid(valid), .i_op(op),
        .i_imm(imm), .i_src_base(base), .i_src_data(sdata), .i_tag(tag),
        .o_stall(stall), .i_fill(fill), .i_retire(retire), .i_sq_full(sq_full),
        .o_sq_retire_stall(sq_stall), .i_replay(replay), .i_lq_full(lq_full),
        .o_lq_replay_stall(lq_stall), .o_alloc_lq_en(alloc_lq_en),
        .o_alloc_sq_en(alloc_sq_en), .o_alloc_op(alloc_op), .o_alloc_tag(alloc_tag),
        .o_alloc_addr(alloc_addr), .o_alloc_data(alloc_data), .o_result(result)
    );

    function automatic bit is_load(op_t o);
        return o inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic bit is_store(op_t o);
        return o inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic int op_bytes(op_t o);
        if (o inside {OP_LB, OP_LBU, OP_SB}) return 1;
        if (o inside {OP_LH, OP_LHU, OP_SH}) return 2;
        return 4;
    endfunction

    function automatic op_t rand_op(bit st_only);
        int r;
        r = st_only ? 5 + int'($urandom_range(2)) : int'($urandom_range(7));
        case (r)
            0: return OP_LB;
            1: return OP_LH;
            2: return OP_LW;
            3: return OP_LBU;
            4: return OP_LHU;
            5: return OP_SB;
            6: return OP_SH;
            default: return OP_SW;
        endcase
    endfunction

    // Three regions alias onto the same sets and are aligned to the access size
    function automatic addr_t rand_addr(op_t o);
        addr_t a;
        a = 32'h1000 + addr_t'($urandom_range(2)) * 32'h2000 + addr_t'($urandom_range(127));
        return a & ~addr_t'(op_bytes(o) - 1);
    endfunction

    // Backing memory holds a scramble of the full word address
    function automatic line_t pattern_line(addr_t la);
        line_t l;
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            l[w*32 +: 32] = ((la + addr_t'(w * 4)) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
        end
        return l;
    endfunction

    function automatic int set_of(addr_t a);
        return int'((a >> OFF_W) & addr_t'(SETS - 1));
    endfunction

    function automatic bit line_hit(addr_t a);
        return m_valid[set_of(a)] && (m_tag[set_of(a)] == (a >> (OFF_W + IDX_W)));
    endfunction

    function automatic data_t load_value(op_t o, addr_t a);
        data_t v;
        int    off;
        v   = '0;
        off = int'(a[OFF_W-1:0]);
        for (int b = 0; b < op_bytes(o); b++) begin
            v[b*8 +: 8] = m_line[set_of(a)][(off + b)*8 +: 8];
        end
        if (o == OP_LB) v = {{24{v[7]}}, v[7:0]};
        if (o == OP_LH) v = {{16{v[15]}}, v[15:0]};
        return v;
    endfunction

    function automatic logic stall_rule();
        return (lq_full & is_load(op)) | (sq_full & is_store(op)) |
               fill.en | retire.en | replay.en;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic set_fill(input addr_t a);
        fill.en   = 1'b1;
        fill.addr = {a[31:OFF_W], {OFF_W{1'b0}}};
        fill.line = pattern_line(fill.addr);
    endtask

    task automatic drive_inputs(input bit active);
        data_t r;
        valid   = 1'b0;
        flush   = 1'b0;
        lq_full = 1'b0;
        sq_full = 1'b0;
        fill    = '0;
        replay  = '0;
        if (ret_taken || !active) retire = '0;
        ret_taken = 1'b0;
        if (!active) return;
        flush   = ($urandom_range(15) == 0);
        lq_full = ($urandom_range(7) == 0);
        sq_full = ($urandom_range(7) == 0);
        // The oldest miss gets its line filled first, then is replayed
        if (miss_q.size() > 0 && $urandom_range(2) == 0) begin
            if (line_hit(miss_q[0].addr)) replay = miss_q[0];
            else set_fill(miss_q[0].addr);
        end else if ($urandom_range(9) == 0) begin
            set_fill(rand_addr(OP_LW));
        end
        if (!retire.en && $urandom_range(5) == 0) begin
            retire.en   = 1'b1;
            retire.op   = rand_op(1'b1);
            retire.tag  = tag_t'($urandom);
            retire.addr = rand_addr(retire.op);
            retire.data = $urandom;
        end
        r     = $urandom;
        valid = ($urandom_range(3) != 0);
        op    = rand_op(1'b0);
        tag   = tag_t'($urandom);
        imm   = {{20{r[11]}}, r[11:0]};
        base  = rand_addr(op) - imm;
        sdata = $urandom;
    endtask

    task automatic check_stalls();
        compare("o_stall", 32'(stall), 32'(stall_rule()));
        compare("o_sq_retire_stall", 32'(sq_stall), 32'(flush | fill.en));
        compare("o_lq_replay_stall", 32'(lq_stall), 32'(retire.en | fill.en));
    endtask

    task automatic load_result(input op_t o, input addr_t a, input tag_t t, input exp_t e);
        replay_t m;
        e.res.tag  = t;
        e.res.addr = a;
        if (line_hit(a)) begin
            e.res.kind = KIND_DONE;
            e.res.data = load_value(o, a);
        end else begin
            e.res.kind = KIND_MISS;
            m.en   = 1'b1;
            m.tag  = t;
            m.addr = a;
            m.op   = o;
            miss_q.push_back(m);
        end
        exp_q.push_back(e);
    endtask

    // Model the source that enters at the coming edge by priority
    task automatic predict(input int cyc);
        exp_t e;
        logic take_new;
        int   s;
        int   off;
        take_new = valid & ~stall_rule() & ~flush;
        exp_lq   = take_new & is_load(op);
        exp_sq   = take_new & is_store(op);
        exp_op   = op;
        exp_tag  = tag;
        exp_addr = base + imm;
        exp_data = sdata;
        e           = '0;
        e.stamp     = cyc + 3;
        e.res.valid = 1'b1;
        if (fill.en) begin
            s          = set_of(fill.addr);
            m_valid[s] = 1'b1;
            m_tag[s]   = fill.addr >> (OFF_W + IDX_W);
            m_line[s]  = fill.line;
        end else if (retire.en && !flush) begin
            ret_taken  = 1'b1;
            e.res.tag  = retire.tag;
            e.res.addr = retire.addr;
            e.res.kind = KIND_MISS;
            if (line_hit(retire.addr)) begin
                s   = set_of(retire.addr);
                off = int'(retire.addr[OFF_W-1:0]);
                for (int b = 0; b < op_bytes(retire.op); b++) begin
                    m_line[s][(off + b)*8 +: 8] = retire.data[b*8 +: 8];
                end
                e.res.kind = KIND_RETIRED;
            end
            exp_q.push_back(e);
        end else if (replay.en && !flush) begin
            void'(miss_q.pop_front());
            load_result(replay.op, replay.addr, replay.tag, e);
        end else if (take_new && is_load(op)) begin
            load_result(op, base + imm, tag, e);
        end else if (take_new) begin
            e.res.tag  = tag;
            e.res.addr = base + imm;
            exp_q.push_back(e);
        end
    endtask

    task automatic check_outputs(input int cyc);
        exp_t e;
        compare("o_alloc_lq_en", 32'(alloc_lq_en), 32'(exp_lq));
        compare("o_alloc_sq_en", 32'(alloc_sq_en), 32'(exp_sq));
        if (exp_lq || exp_sq) begin
            compare("o_alloc_op", 32'(alloc_op), 32'(exp_op));
            compare("o_alloc_tag", 32'(alloc_tag), 32'(exp_tag));
            compare("o_alloc_addr", alloc_addr, exp_addr);
            compare("o_alloc_data", alloc_data, exp_data);
        end
        if (exp_q.size() > 0 && exp_q[0].stamp == cyc) begin
            e = exp_q.pop_front();
            compare("o_result.valid", 32'(result.valid), 32'd1);
            compare("o_result.kind", 32'(result.kind), 32'(e.res.kind));
            compare("o_result.tag", 32'(result.tag), 32'(e.res.tag));
            compare("o_result.addr", result.addr, e.res.addr);
            compare("o_result.data", result.data, e.res.data);
        end else begin
            compare("o_result.valid", 32'(result.valid), 32'd0);
        end
    endtask

    initial begin
        repeat (N_OPS * 10 + 100) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", N_OPS * 10 + 100);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h1d21));
        valid     = 1'b0;
        flush     = 1'b0;
        lq_full   = 1'b0;
        sq_full   = 1'b0;
        op        = OP_LW;
        imm       = '0;
        base      = '0;
        sdata     = '0;
        tag       = '0;
        fill      = '0;
        retire    = '0;
        replay    = '0;
        m_valid   = '0;
        exp_lq    = 1'b0;
        exp_sq    = 1'b0;
        ret_taken = 1'b0;
        errors    = 0;
        checks    = 0;
        @(posedge rst_n);
        // Last four cycles are idle so the pipeline drains
        for (int k = 0; k < N_OPS + 4; k++) begin
            @(negedge clk);
            check_outputs(k);
            drive_inputs(k < N_OPS);
            #1;
            check_stalls();
            predict(k);
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never appeared on o_result", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
hdl/lsu_pkg.sv
hdl/lsu_decode.sv
hdl/lsu_am.sv
hdl/lsu_exec.sv
hdl/lsu_result.sv
hdl/lsu_top.sv
test/lsu_clkgen.sv
test/lsu_tb.sv

// File: Makefile
# Verilator build and run for the LSU front end

VERILATOR  ?= verilator
TOP        ?= lsu_tb
RTL_TOP    ?= lsu_top
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary -j 0 --timing
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Test OK" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
